// File: chien_search.f
+incdir+include
source/gf_pkg.sv
source/chien_pkg.sv
source/gf_mult.sv
source/chien_term_column.sv
source/chien_sum_check.sv
source/chien_ctrl.sv
source/chien_search.sv
sim/chien_search_tb.sv

// File: include/chien_params.svh
`ifndef CHIEN_PARAMS_SVH
`define CHIEN_PARAMS_SVH

// Field GF(2^8) with x^8+x^4+x^3+x^2+1
`define GF_WIDTH 8
`define GF_POLY 9'h11D

// Highest locator degree, so MAX_DEGREE+1 coefficient columns
`define MAX_DEGREE 8

// Positions tested per clock
`define PAR_WAYS 4

// Code length of the RS code and the number of search blocks
`define CODE_LEN 255
`define NUM_BLOCKS ((`CODE_LEN + `PAR_WAYS) / `PAR_WAYS)

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the Chien search testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module chien_search_tb \
    -f chien_search.f

if ! ./obj_dir/Vchien_search_tb > sim.log 2>&1
then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log
then
    exit 0
fi
exit 1

// File: sim/chien_search_stim.txt
// sigma0 sigma1 ... sigma8, then the expected root count, all hex
// one locator per line
01 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 ff
01 01 00 00 00 00 00 00 00 01
02 01 00 00 00 00 00 00 00 01
8e 8f 01 00 00 00 00 00 00 02
08 06 01 00 00 00 00 00 00 02
01 00 00 01 00 00 00 00 00 03
01 00 00 00 00 01 00 00 00 05
01 00 00 00 00 00 00 00 01 01
00 01 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 01 00
00 01 00 00 01 00 00 00 00 03

// File: sim/chien_search_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module chien_search_tb;

    import chien_pkg::*;

    localparam int NUM_CASES    = 12;
    localparam int CASE_WORDS   = `MAX_DEGREE + 2;
    localparam int NUM_RANDOM   = 20;
    localparam int START_WAIT   = 8;
    localparam int INJECT_BLOCK = 10;
    localparam int LAST         = `NUM_BLOCKS - 1;

    logic          clk;
    logic          reset;
    logic          start;
    locator_t      locator;
    logic          busy;
    logic          result_valid;
    chien_result_t result;
    logic          done;

    logic [7:0]           stim_mem [0:NUM_CASES*CASE_WORDS-1];
    logic [7:0]           alpha_tab [0:`CODE_LEN-1];
    logic [`PAR_WAYS-1:0] exp_mask [0:`NUM_BLOCKS-1];
    int                   exp_roots;
    logic [31:0]          lfsr_state;
    int                   errors;
    int                   timeouts;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    chien_search i_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .locator      (locator),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .done         (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Shift-and-add multiply, x^8 folds to x^4+x^3+x^2+1
    function automatic logic [7:0] ref_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1D : 8'h00);
        end
        return p;
    endfunction

    function automatic void build_alpha_table();
        alpha_tab[0] = 8'h01;
        for (int n = 1; n < `CODE_LEN; n++)
        begin
            alpha_tab[n] = ref_mul(alpha_tab[n-1], 8'h02);
        end
    endfunction

    // sigma(alpha^pos)
    function automatic logic [7:0] eval_at(input locator_t loc, input int pos);
        logic [7:0] sum;
        sum = 8'h00;
        for (int j = 0; j <= `MAX_DEGREE; j++)
        begin
            sum = sum ^ ref_mul(loc.coeff[j], alpha_tab[(pos * j) % `CODE_LEN]);
        end
        return sum;
    endfunction

    function automatic void compute_model(input locator_t loc);
        int pos;
        exp_roots = 0;
        for (int b = 0; b < `NUM_BLOCKS; b++)
        begin
            for (int k = 0; k < `PAR_WAYS; k++)
            begin
                pos = b * `PAR_WAYS + k;
                exp_mask[b][k] = (pos < `CODE_LEN) && (eval_at(loc, pos) == 8'h00);
                if (exp_mask[b][k])
                    exp_roots++;
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Random locators
    ////////////////////////////////////////////////////////////////////////////

    // Galois form of x^32+x^22+x^2+x+1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            value = {value[6:0], lfsr_bit()};
        end
        return value;
    endfunction

    // Either raw coefficients or a monic product of (x + alpha^r)
    function automatic locator_t random_locator(input logic from_roots);
        locator_t   loc;
        logic [7:0] root;
        int         degree;
        loc = '0;
        if (!from_roots)
        begin
            for (int j = 0; j <= `MAX_DEGREE; j++)
                loc.coeff[j] = random_byte();
        end
        else
        begin
            loc.coeff[0] = 8'h01;
            degree = 1 + (int'(random_byte()) % 8);
            for (int d = 0; d < degree; d++)
            begin
                root = alpha_tab[int'(random_byte()) % `CODE_LEN];
                for (int j = `MAX_DEGREE; j > 0; j--)
                    loc.coeff[j] = loc.coeff[j-1] ^ ref_mul(loc.coeff[j], root);
                loc.coeff[0] = ref_mul(loc.coeff[0], root);
            end
        end
        return loc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One search, checked block by block against exp_mask
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_search(input locator_t loc, input logic inject, input locator_t other,
                              input logic [COUNT_WIDTH-1:0] want_count, input string label);
        int waited;
        int n;
        @(posedge clk);
        start   <= 1'b1;
        locator <= loc;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1)
        begin
            $display("[FAIL] %s: busy=%h exp=1 after start", label, busy);
            errors++;
        end

        waited = 0;
        while (result_valid !== 1'b1 && waited < START_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (result_valid !== 1'b1)
        begin
            $display("%s: no result_valid within %0d cycles of start", label, START_WAIT);
            timeouts++;
            return;
        end
        if (waited != 1)
        begin
            $display("%s: first result came %0d cycles after busy, not 1", label, waited);
            errors++;
        end

        n = 0;
        while (n < `NUM_BLOCKS)
        begin
            if (result_valid !== 1'b1)
            begin
                $display("%s: result_valid dropped after %0d blocks", label, n);
                errors++;
                break;
            end
            if (result.block !== BLOCK_WIDTH'(n))
            begin
                $display("[FAIL] %s: result.block=%h exp=%h", label, result.block, n);
                errors++;
            end
            if (result.root_mask !== exp_mask[n])
            begin
                $display("[FAIL] %s block %0d: result.root_mask=%h exp=%h",
                         label, n, result.root_mask, exp_mask[n]);
                errors++;
            end
            if (done !== (n == LAST) || result.last !== (n == LAST) || busy !== (n != LAST))
            begin
                $display("[FAIL] %s block %0d: done=%h result.last=%h busy=%h exp=%h/%h/%h",
                         label, n, done, result.last, busy, n == LAST, n == LAST, n != LAST);
                errors++;
            end
            if (n == LAST && result.root_count !== want_count)
            begin
                $display("[FAIL] %s: result.root_count=%h exp=%h",
                         label, result.root_count, want_count);
                errors++;
            end
            n++;
            // Second start lands in the middle of the search
            if (inject && n == INJECT_BLOCK)
            begin
                @(posedge clk);
                start   <= 1'b1;
                locator <= other;
            end
            else if (inject && n == INJECT_BLOCK + 1)
            begin
                @(posedge clk);
                start <= 1'b0;
            end
            if (n < `NUM_BLOCKS)
                @(negedge clk);
        end

        if (n == `NUM_BLOCKS)
        begin
            @(negedge clk);
            if (result_valid !== 1'b0 || done !== 1'b0 || busy !== 1'b0)
            begin
                $display("[FAIL] %s after done: result_valid=%h done=%h busy=%h exp=0",
                         label, result_valid, done, busy);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        locator_t               loc;
        logic [COUNT_WIDTH-1:0] file_count;
        errors     = 0;
        timeouts   = 0;
        lfsr_state = 32'ha8c7_f82a;
        reset   <= 1'b1;
        start   <= 1'b0;
        locator <= '0;
        build_alpha_table();
        $readmemh("sim/chien_search_stim.txt", stim_mem);

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || result_valid !== 1'b0 || done !== 1'b0)
        begin
            $display("[FAIL] after reset: busy=%h result_valid=%h done=%h exp=0",
                     busy, result_valid, done);
            errors++;
        end
        if (result.root_count !== '0)
        begin
            $display("[FAIL] after reset: result.root_count=%h exp=0", result.root_count);
            errors++;
        end

        for (int c = 0; c < NUM_CASES; c++)
        begin
            loc = '0;
            for (int j = 0; j <= `MAX_DEGREE; j++)
                loc.coeff[j] = stim_mem[c*CASE_WORDS + j];
            file_count = COUNT_WIDTH'(stim_mem[c*CASE_WORDS + `MAX_DEGREE + 1]);
            compute_model(loc);
            run_search(loc, 1'b0, '0, file_count, $sformatf("stim case %0d", c));
        end

        // x^3+1 with an all-zero locator offered mid-search
        loc = '0;
        loc.coeff[0] = 8'h01;
        loc.coeff[3] = 8'h01;
        compute_model(loc);
        run_search(loc, 1'b1, '0, COUNT_WIDTH'(exp_roots), "ignored start");

        for (int r = 0; r < NUM_RANDOM; r++)
        begin
            loc = random_locator((r % 2) == 1);
            compute_model(loc);
            run_search(loc, 1'b0, '0, COUNT_WIDTH'(exp_roots), $sformatf("random case %0d", r));
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/chien_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module chien_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic                    busy,
    output logic                    load,
    output chien_pkg::search_step_t step
);

    import chien_pkg::*;

    localparam logic [BLOCK_WIDTH-1:0] LAST_BLOCK = BLOCK_WIDTH'(`NUM_BLOCKS - 1);

    ctrl_state_t            state_q;
    logic [BLOCK_WIDTH-1:0] block_q;

    ////////////////////////////////////////////////////////////////////////////
    // Search FSM
    ////////////////////////////////////////////////////////////////////////////

    // Start is only taken while idle
    assign load = start && (state_q == IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= IDLE;
            block_q <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (start)
                    begin
                        state_q <= SEARCH;
                        block_q <= '0;
                    end
                end
                SEARCH:
                begin
                    block_q <= block_q + 1'b1;
                    if (block_q == LAST_BLOCK)
                    begin
                        state_q <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step outputs
    ////////////////////////////////////////////////////////////////////////////

    assign busy        = (state_q == SEARCH);
    assign step.active = busy;
    assign step.last   = busy && (block_q == LAST_BLOCK);
    assign step.block  = block_q;

    a_no_load_in_search: assert property (
        @(posedge clk) disable iff (reset)
        (state_q == SEARCH) |-> !load
    );

endmodule

`default_nettype wire

// File: source/chien_pkg.sv
`default_nettype none

`include "chien_params.svh"

package chien_pkg;

    localparam int BLOCK_WIDTH = $clog2(`NUM_BLOCKS);
    localparam int COUNT_WIDTH = $clog2(`CODE_LEN) + 1;

    // sigma0 in coeff[0] up to sigma8 in coeff[MAX_DEGREE]
    typedef struct packed {
        gf_pkg::gf_elem_t [`MAX_DEGREE:0] coeff;
    } locator_t;

    // One product (or partial sum) per parallel way
    typedef gf_pkg::gf_elem_t [`PAR_WAYS-1:0] way_sums_t;

    // What the controller asks of the datapath in the current cycle
    typedef struct packed {
        logic                   active;
        logic                   last;
        logic [BLOCK_WIDTH-1:0] block;
    } search_step_t;

    typedef struct packed {
        logic [`PAR_WAYS-1:0]   root_mask;
        logic [BLOCK_WIDTH-1:0] block;
        logic [COUNT_WIDTH-1:0] root_count;
        logic                   last;
    } chien_result_t;

    typedef enum logic {
        IDLE,
        SEARCH
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/chien_search.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module chien_search (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  chien_pkg::locator_t      locator,
    output logic                     busy,
    output logic                     result_valid,
    output chien_pkg::chien_result_t result,
    output logic                     done
);

    import chien_pkg::*;

    logic         load;
    search_step_t step;
    way_sums_t    column_products [0:`MAX_DEGREE];

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    chien_ctrl i_ctrl (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .busy  (busy),
        .load  (load),
        .step  (step)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One column per locator coefficient
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j <= `MAX_DEGREE; j++)
    begin : g_column
        chien_term_column #(
            .COLUMN (j)
        ) i_column (
            .clk      (clk),
            .reset    (reset),
            .load     (load),
            .advance  (step.active),
            .coeff    (locator.coeff[j]),
            .products (column_products[j])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Root test and result
    ////////////////////////////////////////////////////////////////////////////

    chien_sum_check i_sum_check (
        .clk             (clk),
        .reset           (reset),
        .column_products (column_products),
        .step            (step),
        .result_valid    (result_valid),
        .result          (result),
        .done            (done)
    );

endmodule

`default_nettype wire

// File: source/chien_sum_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module chien_sum_check (
    input  logic                    clk,
    input  logic                    reset,
    input  chien_pkg::way_sums_t    column_products [0:`MAX_DEGREE],
    input  chien_pkg::search_step_t step,
    output logic                    result_valid,
    output chien_pkg::chien_result_t result,
    output logic                    done
);

    import gf_pkg::*;
    import chien_pkg::*;

    gf_elem_t [`PAR_WAYS-1:0] way_sum;
    logic     [`PAR_WAYS-1:0] root_mask_next;
    logic   [COUNT_WIDTH-1:0] hit_count;

    ////////////////////////////////////////////////////////////////////////////
    // Sum the columns, test for zero
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        hit_count = '0;
        for (int k = 0; k < `PAR_WAYS; k++)
        begin
            way_sum[k] = '0;
            for (int j = 0; j <= `MAX_DEGREE; j++)
            begin
                way_sum[k] = way_sum[k] ^ column_products[j][k];
            end

            // Position 255 aliases position 0
            root_mask_next[k] = (way_sum[k] == '0) &&
                                ((int'(step.block) * `PAR_WAYS + k) < `CODE_LEN);
            hit_count = hit_count + COUNT_WIDTH'(root_mask_next[k]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result register and root counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            done         <= 1'b0;
            result       <= '0;
        end
        else
        begin
            result_valid     <= step.active;
            done             <= step.active && step.last;
            result.root_mask <= step.active ? root_mask_next : '0;
            result.block     <= step.block;
            result.last      <= step.active && step.last;

            // Count restarts with block 0 of each search
            if (step.active)
            begin
                if (step.block == '0)
                    result.root_count <= hit_count;
                else
                    result.root_count <= result.root_count + hit_count;
            end
        end
    end

    a_mask_only_when_valid: assert property (
        @(posedge clk) disable iff (reset)
        !result_valid |-> (result.root_mask == '0)
    );

endmodule

`default_nettype wire

// File: source/chien_term_column.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module chien_term_column #(
    parameter int COLUMN = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 advance,
    input  gf_pkg::gf_elem_t     coeff,
    output chien_pkg::way_sums_t products
);

    import gf_pkg::*;

    // Register moves by PAR_WAYS positions per block
    localparam gf_elem_t STEP_CONST = gf_alpha_pow(COLUMN * `PAR_WAYS);

    gf_elem_t term_q;
    gf_elem_t term_stepped;

    ////////////////////////////////////////////////////////////////////////////
    // Term register: sigma_j * alpha^(j*4b) for the current block b
    ////////////////////////////////////////////////////////////////////////////

    gf_mult i_step_mult (
        .a       (term_q),
        .b       (STEP_CONST),
        .product (term_stepped)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            term_q <= '0;
        end
        else if (load)
        begin
            term_q <= coeff;
        end
        else if (advance)
        begin
            term_q <= term_stepped;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-way products
    ////////////////////////////////////////////////////////////////////////////

    // Way k sees position 4b+k, so it needs an extra alpha^(j*k)
    for (genvar k = 0; k < `PAR_WAYS; k++)
    begin : g_way
        localparam gf_elem_t WAY_CONST = gf_alpha_pow(COLUMN * k);

        gf_mult i_way_mult (
            .a       (term_q),
            .b       (WAY_CONST),
            .product (products[k])
        );
    end

    // Controller only loads from IDLE and only advances in SEARCH
    a_load_advance_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(load && advance)
    );

endmodule

`default_nettype wire

// File: source/gf_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "chien_params.svh"

module gf_mult (
    input  gf_pkg::gf_elem_t a,
    input  gf_pkg::gf_elem_t b,
    output gf_pkg::gf_elem_t product
);

    localparam int PROD_WIDTH = 2 * `GF_WIDTH - 1;

    // Carry-less product before reduction, 15 bits
    logic [PROD_WIDTH-1:0] full;

    always_comb
    begin
        full = '0;

        // Polynomial product over GF(2)
        for (int i = 0; i < `GF_WIDTH; i++)
        begin
            for (int j = 0; j < `GF_WIDTH; j++)
            begin
                full[i+j] = full[i+j] ^ (a[i] & b[j]);
            end
        end

        // Fold the high terms back, top bit first
        for (int i = PROD_WIDTH - 1; i >= `GF_WIDTH; i--)
        begin
            if (full[i])
            begin
                full = full ^ (PROD_WIDTH'(`GF_POLY) << (i - `GF_WIDTH));
            end
        end

        product = full[`GF_WIDTH-1:0];
    end

endmodule

`default_nettype wire

// File: source/gf_pkg.sv
`default_nettype none

`include "chien_params.svh"

package gf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field element
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`GF_WIDTH-1:0] gf_elem_t;

    ////////////////////////////////////////////////////////////////////////////
    // alpha^n, worked out at elaboration time
    ////////////////////////////////////////////////////////////////////////////

    // Multiply by alpha n times, reduce on every carry out of the MSB.
    // The exponent wraps at the multiplicative order of the field.
    function automatic gf_elem_t gf_alpha_pow(input int unsigned n);
        gf_elem_t    value;
        int unsigned steps;
        value = gf_elem_t'(1);
        steps = n % `CODE_LEN;
        for (int unsigned i = 0; i < steps; i++)
        begin
            if (value[`GF_WIDTH-1])
            begin
                value = (value << 1) ^ gf_elem_t'(`GF_POLY);
            end
            else
            begin
                value = value << 1;
            end
        end
        return value;
    endfunction

endpackage

`default_nettype wire
